/* proc_pkg.sv */
package proc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // primary opcode in instr[31:27]
    typedef enum logic [4:0] {
        op_alu  = 5'b00000,
        op_j    = 5'b00001,
        op_bne  = 5'b00010,
        op_jal  = 5'b00011,
        op_jr   = 5'b00100,
        op_addi = 5'b00101,
        op_blt  = 5'b00110,
        op_sw   = 5'b00111,
        op_lw   = 5'b01000
    } opcode_t;

    // alu function field of the register group
    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_t;

    // execute operand source
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } fwd_sel_t;

    // instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 27;
    localparam int RD_HI     = 26;
    localparam int RD_LO     = 22;
    localparam int RS_HI     = 21;
    localparam int RS_LO     = 17;
    localparam int RT_HI     = 16;
    localparam int RT_LO     = 12;
    localparam int SHAMT_HI  = 11;
    localparam int SHAMT_LO  = 7;
    localparam int ALUOP_HI  = 6;
    localparam int ALUOP_LO  = 2;
    // immediate is sign-extended, jump target zero-extended
    localparam int IMM_W     = 17;
    localparam int TARGET_W  = 27;

    // link register for jal
    localparam reg_idx_t REG_RA = 5'd31;
    // add r0, r0, r0
    localparam word_t NOP_INSTR = 32'h0000_0000;

    // opcodes that leave a result in the register file
    function automatic logic writes_reg(opcode_t op);
        return op inside {op_alu, op_addi, op_lw, op_jal};
    endfunction

    // opcodes whose second source is rd instead of rt
    function automatic logic reads_rd(opcode_t op);
        return op inside {op_bne, op_blt, op_jr, op_sw};
    endfunction

endpackage

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  proc_pkg::word_t    a,
    input  proc_pkg::word_t    b,
    input  proc_pkg::alu_op_t  op,
    input  proc_pkg::reg_idx_t shamt,
    output proc_pkg::word_t    result,
    output logic               not_equal,
    output logic               less_than
);
    import proc_pkg::*;

    word_t sum;
    word_t diff;

    // shared adder paths
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            alu_add: result = sum;
            alu_sub: result = diff;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            // shifts act on a only, amount from the shamt field
            alu_sll: result = a << shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            // unused codes fall back to add
            default: result = sum;
        endcase
    end

    // compare flags do not depend on op
    assign not_equal = (a != b);
    // signed compare
    assign less_than = ($signed(a) < $signed(b));

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic               clock,
    input  logic               rst_n,
    input  proc_pkg::reg_idx_t raddr_a,
    input  proc_pkg::reg_idx_t raddr_b,
    output proc_pkg::word_t    rdata_a,
    output proc_pkg::word_t    rdata_b,
    input  logic               wen,
    input  proc_pkg::reg_idx_t waddr,
    input  proc_pkg::word_t    wdata
);
    import proc_pkg::*;

    word_t regs [32];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            // r0 never written
            regs[waddr] <= wdata;
        end
    end

    // write-first so decode sees the value retiring this cycle
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (wen && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (wen && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  proc_pkg::word_t    id_instr,
    input  proc_pkg::word_t    ex_instr,
    input  proc_pkg::word_t    mem_instr,
    input  proc_pkg::reg_idx_t wb_dest,
    input  logic               wb_wen,
    output proc_pkg::fwd_sel_t fwd_a,
    output proc_pkg::fwd_sel_t fwd_b,
    output logic               fwd_store,
    output logic               stall
);
    import proc_pkg::*;

    opcode_t  id_op;
    opcode_t  ex_op;
    opcode_t  mem_op;
    reg_idx_t ex_rs;
    reg_idx_t ex_src_b;
    reg_idx_t ex_rd;
    reg_idx_t mem_rd;
    logic     ex_uses_a;
    logic     ex_uses_b;
    logic     mem_writes;
    logic     wb_writes;

    // first source is rs
    function automatic logic reads_rs(opcode_t op);
        return op inside {op_alu, op_addi, op_lw, op_sw, op_bne, op_blt};
    endfunction

    // only the register group reads rt
    function automatic logic reads_rt(opcode_t op);
        return op == op_alu;
    endfunction

    // memory stage wins over writeback for one operand
    function automatic fwd_sel_t pick(logic used, reg_idx_t src);
        if (used && mem_writes && mem_rd == src) begin
            return fwd_mem;
        end
        if (used && wb_writes && wb_dest == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign id_op  = opcode_t'(id_instr[OPCODE_HI:OPCODE_LO]);
    assign ex_op  = opcode_t'(ex_instr[OPCODE_HI:OPCODE_LO]);
    assign mem_op = opcode_t'(mem_instr[OPCODE_HI:OPCODE_LO]);

    assign ex_rs  = ex_instr[RS_HI:RS_LO];
    assign ex_rd  = ex_instr[RD_HI:RD_LO];
    // mem rd field already carries the real destination (r31 for jal)
    assign mem_rd = mem_instr[RD_HI:RD_LO];

    // port b carries rt or rd depending on opcode
    assign ex_src_b  = reads_rd(ex_op) ? ex_rd : ex_instr[RT_HI:RT_LO];
    assign ex_uses_a = reads_rs(ex_op);
    assign ex_uses_b = reads_rt(ex_op) || reads_rd(ex_op);

    // r0 never forwards
    assign mem_writes = writes_reg(mem_op) && mem_rd != '0;
    assign wb_writes  = wb_wen && wb_dest != '0;

    always_comb begin
        fwd_a = pick(ex_uses_a, ex_rs);
        fwd_b = pick(ex_uses_b, ex_src_b);
    end

    // store data late fix from writeback
    assign fwd_store = (mem_op == op_sw) && wb_writes && wb_dest == mem_rd;

    // load in execute, consumer in decode
    assign stall = (ex_op == op_lw) && ex_rd != '0 && (
        (reads_rs(id_op) && id_instr[RS_HI:RS_LO] == ex_rd) ||
        (reads_rt(id_op) && id_instr[RT_HI:RT_LO] == ex_rd) ||
        (reads_rd(id_op) && id_instr[RD_HI:RD_LO] == ex_rd));

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  proc_pkg::word_t    ex_instr,
    input  proc_pkg::word_t    ex_pc_next,
    input  proc_pkg::word_t    reg_a,
    input  proc_pkg::word_t    reg_b,
    input  proc_pkg::word_t    mem_value,
    input  proc_pkg::word_t    wb_value,
    input  proc_pkg::fwd_sel_t fwd_a,
    input  proc_pkg::fwd_sel_t fwd_b,
    output proc_pkg::word_t    result,
    output proc_pkg::word_t    store_data,
    output proc_pkg::reg_idx_t dest,
    output logic               branch_taken,
    output proc_pkg::word_t    branch_target
);
    import proc_pkg::*;

    opcode_t op;
    alu_op_t alu_sel;
    word_t   imm;
    word_t   target;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_in_b;
    word_t   alu_result;
    logic    neq;
    logic    lt;
    logic    take_bne;
    logic    take_blt;

    function automatic word_t pick(fwd_sel_t sel, word_t reg_val, word_t mem_v, word_t wb_v);
        case (sel)
            fwd_mem: return mem_v;
            fwd_wb:  return wb_v;
            default: return reg_val;
        endcase
    endfunction

    assign op = opcode_t'(ex_instr[OPCODE_HI:OPCODE_LO]);

    // immediate and jump target
    assign imm    = {{(32 - IMM_W){ex_instr[IMM_W-1]}}, ex_instr[IMM_W-1:0]};
    assign target = {{(32 - TARGET_W){1'b0}}, ex_instr[TARGET_W-1:0]};

    // a is rs, b is rt or rd
    assign op_a = pick(fwd_a, reg_a, mem_value, wb_value);
    assign op_b = pick(fwd_b, reg_b, mem_value, wb_value);

    // address and addi arithmetic take the immediate
    assign alu_in_b = (op inside {op_addi, op_lw, op_sw}) ? imm : op_b;

    always_comb begin
        case (op)
            op_alu:         alu_sel = alu_op_t'(ex_instr[ALUOP_HI:ALUOP_LO]);
            op_bne, op_blt: alu_sel = alu_sub;
            default:        alu_sel = alu_add;
        endcase
    end

    alu u_alu (
        .a         (op_a),
        .b         (alu_in_b),
        .op        (alu_sel),
        .shamt     (ex_instr[SHAMT_HI:SHAMT_LO]),
        .result    (alu_result),
        .not_equal (neq),
        .less_than (lt)
    );

    // jal links pc+1
    assign result     = (op == op_jal) ? ex_pc_next : alu_result;
    assign store_data = op_b;
    assign dest       = (op == op_jal) ? REG_RA : ex_instr[RD_HI:RD_LO];

    // bne rd != rs, blt rd < rs i.e. rs > rd
    assign take_bne = (op == op_bne) && neq;
    assign take_blt = (op == op_blt) && neq && !lt;

    assign branch_taken = take_bne || take_blt || (op inside {op_j, op_jal, op_jr});

    always_comb begin
        case (op)
            op_j, op_jal: branch_target = target;
            // jr jumps to forwarded rd
            op_jr:        branch_target = op_b;
            default:      branch_target = ex_pc_next + imm;
        endcase
    end

endmodule

/* processor.sv */
`timescale 1ns/1ps

module processor (
    input  logic            clock,
    input  logic            rst_n,
    output proc_pkg::word_t imem_addr,
    input  proc_pkg::word_t imem_data,
    output proc_pkg::word_t dmem_addr,
    output proc_pkg::word_t dmem_wdata,
    output logic            dmem_wen,
    input  proc_pkg::word_t dmem_rdata
);
    import proc_pkg::*;

    // fetch
    word_t    pc;
    word_t    pc_plus1;
    // fetch/decode
    word_t    fd_pc_next;
    word_t    fd_instr;
    opcode_t  id_op;
    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    word_t    rdata_a;
    word_t    rdata_b;
    // decode/execute
    word_t    dx_pc_next;
    word_t    dx_instr;
    word_t    dx_a;
    word_t    dx_b;
    // execute outputs
    word_t    ex_result;
    word_t    ex_store_data;
    reg_idx_t ex_dest;
    logic     branch_taken;
    word_t    branch_target;
    // hazard outputs
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     fwd_store;
    logic     stall;
    // execute/memory
    word_t    xm_instr;
    word_t    xm_result;
    word_t    xm_store_data;
    opcode_t  mem_op;
    // memory/writeback
    word_t    mw_instr;
    word_t    mw_result;
    word_t    mw_load_data;
    opcode_t  wb_op;
    reg_idx_t wb_dest;
    logic     wb_wen;
    word_t    wb_value;

    assign pc_plus1  = pc + 32'd1;
    assign imem_addr = pc;

    // redirect beats stall and a stall holds the pc
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc_plus1;
        end
    end

    // fetch/decode instr squashed on redirect
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fd_instr <= NOP_INSTR;
        end else if (branch_taken) begin
            fd_instr <= NOP_INSTR;
        end else if (!stall) begin
            fd_instr <= imem_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_next <= pc_plus1;
        end
    end

    // decode register selection
    assign id_op   = opcode_t'(fd_instr[OPCODE_HI:OPCODE_LO]);
    assign raddr_a = fd_instr[RS_HI:RS_LO];
    assign raddr_b = reads_rd(id_op) ? fd_instr[RD_HI:RD_LO] : fd_instr[RT_HI:RT_LO];

    reg_file u_reg_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wen     (wb_wen),
        .waddr   (wb_dest),
        .wdata   (wb_value)
    );

    // bubble into execute on load-use stall or redirect
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dx_instr <= NOP_INSTR;
        end else if (branch_taken || stall) begin
            dx_instr <= NOP_INSTR;
        end else begin
            dx_instr <= fd_instr;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc_next <= fd_pc_next;
        dx_a       <= rdata_a;
        dx_b       <= rdata_b;
    end

    hazard_unit u_hazard_unit (
        .id_instr  (fd_instr),
        .ex_instr  (dx_instr),
        .mem_instr (xm_instr),
        .wb_dest   (wb_dest),
        .wb_wen    (wb_wen),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .fwd_store (fwd_store),
        .stall     (stall)
    );

    execute_stage u_execute_stage (
        .ex_instr      (dx_instr),
        .ex_pc_next    (dx_pc_next),
        .reg_a         (dx_a),
        .reg_b         (dx_b),
        .mem_value     (xm_result),
        .wb_value      (wb_value),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .result        (ex_result),
        .store_data    (ex_store_data),
        .dest          (ex_dest),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    // rd field rewritten with the real destination
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xm_instr <= NOP_INSTR;
            mw_instr <= NOP_INSTR;
        end else begin
            xm_instr <= {dx_instr[OPCODE_HI:OPCODE_LO], ex_dest, dx_instr[RS_HI:0]};
            mw_instr <= xm_instr;
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= ex_result;
        xm_store_data <= ex_store_data;
        mw_result     <= xm_result;
        mw_load_data  <= dmem_rdata;
    end

    // memory stage drives dmem
    assign mem_op     = opcode_t'(xm_instr[OPCODE_HI:OPCODE_LO]);
    assign dmem_addr  = xm_result;
    assign dmem_wdata = fwd_store ? wb_value : xm_store_data;
    assign dmem_wen   = (mem_op == op_sw);

    // r0 writes dropped in writeback so the nop keeps wen low
    assign wb_op    = opcode_t'(mw_instr[OPCODE_HI:OPCODE_LO]);
    assign wb_dest  = mw_instr[RD_HI:RD_LO];
    assign wb_wen   = writes_reg(wb_op) && wb_dest != '0;
    assign wb_value = (wb_op == op_lw) ? mw_load_data : mw_result;

endmodule

/* tb_processor_sva.sv */
`timescale 1ns/1ps

module port_protocol_checks (
    input logic            clock,
    input logic            rst_n,
    input logic            dmem_wen,
    input proc_pkg::word_t imem_addr,
    input proc_pkg::word_t dx_pc_next
);

    // once reset has been seen for an edge, no store strobe
    no_store_in_reset: assert property (@(posedge clock)
        (!rst_n && $past(!rst_n)) |-> !dmem_wen)
        else $error("dmem_wen high while in reset");

    // back-to-back strobes come from two sw at different addresses
    // a sw held in decode by a stall reaches execute only once
    paired_stores: assert property (@(posedge clock) disable iff (!rst_n)
        (dmem_wen && $past(dmem_wen)) |-> ($past(dx_pc_next) != $past(dx_pc_next, 2)))
        else $error("dmem_wen high two cycles without two sw instructions");

    fetch_addr_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown(imem_addr))
        else $error("imem_addr unknown after reset");

endmodule

bind processor port_protocol_checks u_port_protocol_checks (
    .clock      (clock),
    .rst_n      (rst_n),
    .dmem_wen   (dmem_wen),
    .imem_addr  (imem_addr),
    .dx_pc_next (dx_pc_next)
);

/* tb_processor.sv */
`timescale 1ns/1ps

module tb_processor;
    import proc_pkg::*;

    // program kinds in the case table
    localparam logic [2:0] kind_alu      = 3'd0;
    localparam logic [2:0] kind_load_use = 3'd1;
    localparam logic [2:0] kind_bne      = 3'd2;
    localparam logic [2:0] kind_blt      = 3'd3;
    localparam logic [2:0] kind_jal      = 3'd4;
    // jal sits at this address in its program
    localparam word_t jal_addr = 32'd1;

    typedef struct packed {
        logic [2:0] kind;
        logic [4:0] fn;
        logic       taken;
        word_t      a;
        word_t      b;
        word_t      expected;
    } row_t;

    logic  clock = 1'b0;
    logic  rst_n = 1'b0;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_wen;
    word_t dmem_rdata;

    word_t imem [256];
    word_t dmem [256];
    row_t  rows [$];
    // observed and expected store addresses and data
    word_t store_addr_q [$];
    word_t store_data_q [$];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    int    cycle_count = 0;
    // grows by 40 cycles per loaded instruction
    int    budget = 100;

    always #5 clock = ~clock;

    processor u_processor (
        .clock      (clock),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .dmem_rdata (dmem_rdata)
    );

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    initial begin
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd0d0_0000 + i;
        end
    end

    always @(posedge clock) begin
        if (dmem_wen === 1'b1) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    // store monitor
    always @(posedge clock) begin
        if (dmem_wen === 1'b1) begin
            store_addr_q.push_back(dmem_addr);
            store_data_q.push_back(dmem_wdata);
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // watchdog
    initial begin
        while (cycle_count <= budget) begin
            @(posedge clock);
        end
        $display("watchdog: run did not finish within %0d cycles", budget);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic compare(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s (got %h, expected %h)", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // instruction encoders
    function automatic word_t alu_instr(logic [4:0] fn, reg_idx_t rd, reg_idx_t rs,
                                        reg_idx_t rt, reg_idx_t shamt);
        return {op_alu, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic word_t imm_instr(logic [4:0] op, reg_idx_t rd, reg_idx_t rs,
                                        word_t imm);
        return {op, rd, rs, imm[16:0]};
    endfunction

    function automatic word_t jump_instr(logic [4:0] op, word_t target);
        return {op, target[26:0]};
    endfunction

    function automatic word_t sign_extend17(word_t v);
        return {{15{v[16]}}, v[16:0]};
    endfunction

    // expected register group result with the shift amount in b
    function automatic word_t alu_expected(logic [4:0] fn, word_t a, word_t b);
        case (fn)
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_sll: return a << b[4:0];
            alu_sra: return word_t'($signed(a) >>> b[4:0]);
            default: return a + b;
        endcase
    endfunction

    function automatic row_t make_row(logic [2:0] kind, logic [4:0] fn, logic taken);
        row_t  r;
        word_t tmp;
        r.kind  = kind;
        r.fn    = fn;
        r.taken = taken;
        r.a     = sign_extend17($urandom());
        r.b     = sign_extend17($urandom());
        case (kind)
            kind_alu:      r.expected = alu_expected(fn, r.a, r.b);
            kind_load_use: r.expected = r.a + r.a;
            kind_bne, kind_blt: begin
                // force distinct operands, then steer the outcome
                if (r.a == r.b) begin
                    r.b = r.a ^ 32'd1;
                end
                if (kind == kind_bne && !taken) begin
                    r.b = r.a;
                end
                if (kind == kind_blt && (($signed(r.a) < $signed(r.b)) != taken)) begin
                    tmp = r.a;
                    r.a = r.b;
                    r.b = tmp;
                end
                // landing store writes r1
                r.expected = r.a;
            end
            default: r.expected = jal_addr + 32'd1;
        endcase
        return r;
    endfunction

    task automatic expect_store(word_t addr, word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // unused slots hold a jump to themselves, so every program halts
    task automatic load_program(row_t r);
        int len;
        for (int i = 0; i < 256; i++) begin
            imem[i] = jump_instr(op_j, word_t'(i));
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        imem[0] = imm_instr(op_addi, 5'd1, 5'd0, r.a);
        case (r.kind)
            kind_alu: begin
                imem[1] = imm_instr(op_addi, 5'd2, 5'd0, r.b);
                imem[2] = alu_instr(r.fn, 5'd3, 5'd1, 5'd2, r.b[4:0]);
                imem[3] = imm_instr(op_sw, 5'd3, 5'd0, 32'd16);
                len = 5;
                expect_store(32'd16, r.expected);
            end
            kind_load_use: begin
                imem[1] = imm_instr(op_sw, 5'd1, 5'd0, 32'd20);
                imem[2] = imm_instr(op_lw, 5'd4, 5'd0, 32'd20);
                imem[3] = alu_instr(alu_add, 5'd5, 5'd4, 5'd4, 5'd0);
                imem[4] = imm_instr(op_sw, 5'd5, 5'd0, 32'd21);
                len = 6;
                expect_store(32'd20, r.a);
                expect_store(32'd21, r.expected);
            end
            kind_bne, kind_blt: begin
                imem[1] = imm_instr(op_addi, 5'd2, 5'd0, r.b);
                // taken target is pc+1+2 past both markers
                imem[2] = imm_instr((r.kind == kind_bne) ? op_bne : op_blt,
                                    5'd1, 5'd2, 32'd2);
                imem[3] = imm_instr(op_sw, 5'd1, 5'd0, 32'd30);
                imem[4] = imm_instr(op_sw, 5'd2, 5'd0, 32'd31);
                imem[5] = imm_instr(op_sw, 5'd1, 5'd0, 32'd32);
                len = 7;
                if (!r.taken) begin
                    expect_store(32'd30, r.a);
                    expect_store(32'd31, r.b);
                end
                expect_store(32'd32, r.expected);
            end
            default: begin
                imem[jal_addr[7:0]] = jump_instr(op_jal, 32'd5);
                imem[2] = imm_instr(op_sw, 5'd1, 5'd0, 32'd41);
                // subroutine at 5
                imem[5] = imm_instr(op_sw, REG_RA, 5'd0, 32'd40);
                imem[6] = imm_instr(op_jr, REG_RA, 5'd0, 32'd0);
                len = 7;
                expect_store(32'd40, r.expected);
                expect_store(32'd41, r.a);
            end
        endcase
        budget += 40 * len;
    endtask

    task automatic run_case(row_t r, int idx);
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        load_program(r);
        @(posedge clock);
        #1;
        // reset has taken hold, nothing may be stored from here
        store_addr_q.delete();
        store_data_q.delete();
        repeat (2) @(posedge clock);
        #1;
        compare(store_addr_q.size(), 32'd0, $sformatf("row %0d store during reset", idx));
        rst_n = 1'b1;
        compare(imem_addr, 32'd0, $sformatf("row %0d first fetch address", idx));
        while (store_data_q.size() < exp_data_q.size()) begin
            @(posedge clock);
        end
        // drain the pipeline to catch stray stores
        repeat (6) @(posedge clock);
        #1;
        compare(store_data_q.size(), exp_data_q.size(), $sformatf("row %0d store count", idx));
        foreach (exp_data_q[i]) begin
            compare(store_addr_q[i], exp_addr_q[i],
                    $sformatf("row %0d store %0d address", idx, i));
            compare(store_data_q[i], exp_data_q[i],
                    $sformatf("row %0d store %0d data", idx, i));
        end
    endtask

    initial begin
        void'($urandom(70));
        rows.push_back(make_row(kind_alu, alu_add, 1'b0));
        rows.push_back(make_row(kind_alu, alu_sub, 1'b0));
        rows.push_back(make_row(kind_alu, alu_and, 1'b0));
        rows.push_back(make_row(kind_alu, alu_or, 1'b0));
        rows.push_back(make_row(kind_alu, alu_sll, 1'b0));
        rows.push_back(make_row(kind_alu, alu_sra, 1'b0));
        rows.push_back(make_row(kind_load_use, alu_add, 1'b0));
        rows.push_back(make_row(kind_bne, alu_add, 1'b1));
        rows.push_back(make_row(kind_bne, alu_add, 1'b0));
        rows.push_back(make_row(kind_blt, alu_add, 1'b1));
        rows.push_back(make_row(kind_blt, alu_add, 1'b0));
        rows.push_back(make_row(kind_jal, alu_add, 1'b0));
        foreach (rows[i]) begin
            run_case(rows[i], i);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* all.f */
proc_pkg.sv
alu.sv
reg_file.sv
hazard_unit.sv
execute_stage.sv
processor.sv
tb_processor_sva.sv
tb_processor.sv

/* Makefile */
# Verilator build and run for the pipelined processor testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_processor -f all.f -o sim_processor

run: compile
	./obj_dir/sim_processor | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
